// ==== dv/distrib_ref.svh ====
// ----------------------------------------------------------------------------
// reference model of the distributor and the random bit source
// ----------------------------------------------------------------------------
`ifndef distrib_ref_svh
`define distrib_ref_svh

// galois lfsr, x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] lfsr_taps = 32'h8020_0003;
localparam logic [31:0] lfsr_seed = 32'h1f47_b781;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic [31:0] nxt;
  nxt = state >> 1;
  if (state[0]) begin
    nxt = nxt ^ lfsr_taps;
  end
  return nxt;
endfunction

// number of set slots in a class mask
function automatic int ones(input distrib_pkg::slot_mask_t m);
  int n;
  n = 0;
  for (int j = 0; j < distrib_pkg::num_slots; j++) begin
    n = n + int'(m[j]);
  end
  return n;
endfunction

// expected physical ports for one bundle; pointers are plain indices 0..2
function automatic distrib_pkg::port_vec_t ref_distrib(
  input distrib_pkg::class_masks_t b,
  input int                        load_r,
  input int                        shift_r
);
  distrib_pkg::slot_mask_t st_l [distrib_pkg::num_slots];
  distrib_pkg::slot_mask_t ld_l [distrib_pkg::num_slots];
  distrib_pkg::slot_mask_t sh_l [distrib_pkg::num_slots];
  distrib_pkg::slot_mask_t al_l [distrib_pkg::num_slots];
  distrib_pkg::port_vec_t  logical;
  distrib_pkg::port_vec_t  phys;
  distrib_pkg::slot_mask_t onehot;
  int ns;
  int nl;
  int nsh;
  int na;
  int a;
  int r;

  ns = 0;
  nl = 0;
  nsh = 0;
  na = 0;
  // slot lists of each class, lowest slot first
  for (int j = 0; j < distrib_pkg::num_slots; j++) begin
    onehot = distrib_pkg::slot_mask_t'(1) << j;
    if (b.store[j]) begin
      st_l[ns] = onehot;
      ns = ns + 1;
    end
    if (b.load[j]) begin
      ld_l[nl] = onehot;
      nl = nl + 1;
    end
    if (b.shift[j]) begin
      sh_l[nsh] = onehot;
      nsh = nsh + 1;
    end
    if (b.alu[j]) begin
      al_l[na] = onehot;
      na = na + 1;
    end
  end

  for (int p = 0; p < distrib_pkg::num_ports; p++) begin
    logical[p] = distrib_pkg::no_slot;
  end
  for (int k = 0; k < ns; k++) begin
    logical[k] = st_l[k];
  end
  for (int k = 0; k < nl; k++) begin
    logical[ns+k] = ld_l[k];
  end
  for (int k = 0; k < nsh; k++) begin
    logical[distrib_pkg::num_ports-1-k] = sh_l[k];
  end

  // alu ops fill the gap between memory ops and shifts
  a = 0;
  for (int p = ns + nl; p < distrib_pkg::num_ports - nsh; p++) begin
    if (a < na) begin
      logical[p] = al_l[a];
      a = a + 1;
    end
  end

  for (int g = 0; g < 3; g++) begin
    r = (g == 2) ? shift_r : load_r;
    for (int i = 0; i < 3; i++) begin
      phys[3*g+i] = logical[3*g+((i+r)%3)];
    end
  end
  return phys;
endfunction

`endif

// ==== dv/distrib_tb.sv ====
// ----------------------------------------------------------------------------
// testbench for the instruction distributor: stimulus, model compare, report
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module distrib_tb;

  localparam int reset_cycles = 5;
  localparam int idle_len     = 3;
  localparam int mem_len      = 150;
  localparam int mix_len      = 250;
  localparam int adv_len      = 12;
  localparam int stall_len    = 6;
  // each test adds one idle cycle in front and one closing cycle
  localparam int stim_cycles  = reset_cycles + (idle_len + 2) + (mem_len + 2) +
                                (mix_len + 2) + (adv_len + 2) + (2 * stall_len + 2);
  localparam int cycle_limit  = 2 * stim_cycles + 20;

  logic                      clk;
  logic                      rst;
  logic                      stall;
  distrib_pkg::class_masks_t bundle;
  distrib_pkg::port_vec_t    ports;

  logic [31:0]            lfsr_state;
  int                     load_r;
  int                     shift_r;
  distrib_pkg::port_vec_t exp_ports;
  bit                     check_pending;
  string                  cur_test;
  int                     checks;
  int                     test_errs;
  int                     pass_tests;
  int                     fail_tests;
  int                     cycles = 0;

  `include "distrib_ref.svh"

  distrib_top u_dut (
    .clk    (clk),
    .rst    (rst),
    .stall  (stall),
    .bundle (bundle),
    .ports  (ports)
  );

  always #2 clk = ~clk;

  // n random bits taking one lfsr step per bit
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // random bundle that respects the front end limits
  function automatic distrib_pkg::class_masks_t rand_bundle(input bit mem_only);
    distrib_pkg::class_masks_t b;
    int code;
    int ns;
    int nl;
    int nsh;
    int na;
    int total;
    b = '0;
    ns = 0;
    nl = 0;
    nsh = 0;
    na = 0;
    total = 0;
    for (int j = 0; j < distrib_pkg::num_slots; j++) begin
      code = take_bits(3);
      if (mem_only) begin
        code = (code < 2) ? 0 : (code < 5) ? 4 : 6;
      end
      if (total < 9) begin
        if (code >= 6 && ns < 3 && ns + nl < 6) begin
          b.store[j] = 1'b1;
          ns = ns + 1;
          total = total + 1;
        end else if (code >= 4 && code < 6 && ns + nl < 6) begin
          b.load[j] = 1'b1;
          nl = nl + 1;
          total = total + 1;
        end else if (code == 3 && nsh < 3) begin
          b.shift[j] = 1'b1;
          nsh = nsh + 1;
          total = total + 1;
        end else if ((code == 1 || code == 2) && na < distrib_pkg::max_rank) begin
          // only max_rank alu ranks reach the placement logic
          b.alu[j] = 1'b1;
          na = na + 1;
          total = total + 1;
        end
      end
    end
    return b;
  endfunction

  // consecutive slots from offset with wrap, as stores then loads then shifts then alu ops
  function automatic distrib_pkg::class_masks_t make_bundle(
    input int nst, input int nld, input int nsh, input int nal, input int offset
  );
    distrib_pkg::class_masks_t b;
    int s;
    b = '0;
    s = offset;
    for (int k = 0; k < nst + nld + nsh + nal; k++) begin
      if (k < nst) b.store[s % 10] = 1'b1;
      else if (k < nst + nld) b.load[s % 10] = 1'b1;
      else if (k < nst + nld + nsh) b.shift[s % 10] = 1'b1;
      else b.alu[s % 10] = 1'b1;
      s = s + 1;
    end
    return b;
  endfunction

  task automatic check_slot(input string name, input int port,
                            input distrib_pkg::slot_mask_t exp,
                            input distrib_pkg::slot_mask_t act, output bit bad);
    bad = (act !== exp);
    if (bad) begin
      $display("FAIL %s port %0d expected %h actual %h", name, port, exp, act);
    end
  endtask

  task automatic check_ports(input string name, input distrib_pkg::port_vec_t exp,
                             input distrib_pkg::port_vec_t act);
    bit bad;
    bit seen;
    seen = 0;
    checks = checks + 1;
    if (act !== exp) begin
      // only the first wrong port is reported
      for (int p = 0; p < distrib_pkg::num_ports; p++) begin
        if (!seen) begin
          check_slot(name, p, exp[p], act[p], bad);
          seen = bad;
        end
      end
      test_errs = test_errs + 1;
    end
  endtask

  // drive one bundle and advance the model pointers as the DUT will
  task automatic apply(input distrib_pkg::class_masks_t b, input logic st);
    @(negedge clk);
    bundle = b;
    stall = st;
    exp_ports = ref_distrib(b, load_r, shift_r);
    check_pending = 1'b1;
    if (!st) begin
      load_r = (load_r + ones(b.load)) % 3;
      shift_r = (shift_r + ones(b.shift)) % 3;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errs = 0;
    checks = 0;
  endtask

  // idle bundle so the pointers hold until the next test
  task automatic end_test();
    @(negedge clk);
    bundle = '0;
    stall = 1'b0;
    check_pending = 1'b0;
    if (test_errs == 0) begin
      pass_tests = pass_tests + 1;
      $display("test %s passed, %0d checks", cur_test, checks);
    end else begin
      fail_tests = fail_tests + 1;
      $display("test %s failed, %0d of %0d checks wrong", cur_test, test_errs, checks);
    end
  endtask

  always @(posedge clk) begin
    if (check_pending) begin
      check_ports(cur_test, exp_ports, ports);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    int nld;
    clk = 1'b0;
    rst = 1'b1;
    stall = 1'b0;
    bundle = '0;
    lfsr_state = lfsr_seed;
    load_r = 0;
    shift_r = 0;
    check_pending = 1'b0;
    cur_test = "reset";
    checks = 0;
    test_errs = 0;
    pass_tests = 0;
    fail_tests = 0;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;

    begin_test("after_reset");
    repeat (idle_len) apply('0, 1'b0);
    end_test();

    begin_test("mem_placement");
    for (int i = 0; i < mem_len; i++) apply(rand_bundle(1'b1), 1'b0);
    end_test();

    begin_test("alu_shift_placement");
    for (int i = 0; i < mix_len; i++) apply(rand_bundle(1'b0), 1'b0);
    end_test();

    // load counts 1, 2, 4 against shift counts 1 to 3
    begin_test("pointer_advance");
    for (int i = 0; i < adv_len; i++) begin
      case (i % 3)
        0: nld = 1;
        1: nld = 2;
        default: nld = 4;
      endcase
      apply(make_bundle(0, nld, 1 + (i / 3) % 3, 2, i), 1'b0);
    end
    end_test();

    begin_test("stall");
    for (int i = 0; i < stall_len; i++) apply(make_bundle(1, 2, 1 + i % 3, 1, i), 1'b1);
    for (int i = 0; i < stall_len; i++) apply(make_bundle(1, 2, 1 + i % 3, 1, i), 1'b0);
    end_test();

    $display("tests passed %0d failed %0d", pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== hdl/distrib_pkg.sv ====
// ----------------------------------------------------------------------------
// types and constants for the issue-stage instruction distributor
// slot masks, rank vectors, port vectors and rotation pointers
// ----------------------------------------------------------------------------
package distrib_pkg;

  // decode width and execution port layout
  localparam int num_slots  = 10;
  localparam int num_ports  = 9;
  localparam int group_size = 3;

  // ranked slots pulled out of each class mask
  localparam int max_rank = 6;

  // one-hot slot select, or a class mask over all slots
  typedef logic [num_slots-1:0] slot_mask_t;

  // an empty port carries all ones
  localparam slot_mask_t no_slot = '1;

  // number of set slots in a mask, 0 to num_slots
  typedef logic [3:0] slot_cnt_t;

  // rank k is the k-th set slot of a class, lowest slot first
  typedef slot_mask_t [max_rank-1:0] rank_vec_t;

  // one decoded bundle split by instruction class
  typedef struct packed {
    slot_mask_t alu;
    slot_mask_t shift;
    slot_mask_t load;
    slot_mask_t store;
  } class_masks_t;

  // one slot select per execution port, index = port number
  typedef slot_mask_t [num_ports-1:0] port_vec_t;

  // one-hot rotation pointer for a three-port group
  typedef logic [group_size-1:0] rot_t;

  // pointers come out of reset at bit 0, i.e. no rotation
  localparam rot_t rot_reset = rot_t'(1);

endpackage

// ==== hdl/distrib_top.sv ====
// ----------------------------------------------------------------------------
// instruction distributor top: class selectors, placement, rotation, pointers
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module distrib_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stall,
  input  distrib_pkg::class_masks_t bundle,
  output distrib_pkg::port_vec_t    ports
);

  distrib_pkg::rank_vec_t alu_ranks;
  distrib_pkg::rank_vec_t shift_ranks;
  distrib_pkg::rank_vec_t load_ranks;
  distrib_pkg::rank_vec_t store_ranks;

  distrib_pkg::slot_cnt_t alu_count;
  distrib_pkg::slot_cnt_t shift_count;
  distrib_pkg::slot_cnt_t load_count;
  distrib_pkg::slot_cnt_t store_count;

  distrib_pkg::port_vec_t logical_ports;
  distrib_pkg::rot_t      load_rot;
  distrib_pkg::rot_t      shift_rot;

  slot_select u_alu_sel (
    .mask  (bundle.alu),
    .ranks (alu_ranks),
    .count (alu_count)
  );

  slot_select u_shift_sel (
    .mask  (bundle.shift),
    .ranks (shift_ranks),
    .count (shift_count)
  );

  slot_select u_load_sel (
    .mask  (bundle.load),
    .ranks (load_ranks),
    .count (load_count)
  );

  slot_select u_store_sel (
    .mask  (bundle.store),
    .ranks (store_ranks),
    .count (store_count)
  );

  port_assign u_assign (
    .alu_ranks     (alu_ranks),
    .shift_ranks   (shift_ranks),
    .load_ranks    (load_ranks),
    .store_ranks   (store_ranks),
    .alu_count     (alu_count),
    .shift_count   (shift_count),
    .load_count    (load_count),
    .store_count   (store_count),
    .logical_ports (logical_ports)
  );

  // ports use this cycle's pointers, the counts only move them for the next
  rotation_ctrl u_rot_ctrl (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .load_count  (load_count),
    .shift_count (shift_count),
    .load_rot    (load_rot),
    .shift_rot   (shift_rot)
  );

  port_rotate u_rotate (
    .logical_ports (logical_ports),
    .load_rot      (load_rot),
    .shift_rot     (shift_rot),
    .ports         (ports)
  );

endmodule

// ==== hdl/port_assign.sv ====
// ----------------------------------------------------------------------------
// unrotated placement of ranked slots onto the nine execution ports
// stores, then loads, then alu ops upward; shifts downward from port 8
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module port_assign (
  input  distrib_pkg::rank_vec_t alu_ranks,
  input  distrib_pkg::rank_vec_t shift_ranks,
  input  distrib_pkg::rank_vec_t load_ranks,
  input  distrib_pkg::rank_vec_t store_ranks,
  input  distrib_pkg::slot_cnt_t alu_count,
  input  distrib_pkg::slot_cnt_t shift_count,
  input  distrib_pkg::slot_cnt_t load_count,
  input  distrib_pkg::slot_cnt_t store_count,
  output distrib_pkg::port_vec_t logical_ports
);

  // selects rank idx of a class; anything past max_rank is empty
  function automatic distrib_pkg::slot_mask_t pick(
    input distrib_pkg::rank_vec_t ranks,
    input int                     idx
  );
    distrib_pkg::slot_mask_t sel;
    sel = distrib_pkg::no_slot;
    for (int k = 0; k < distrib_pkg::max_rank; k++) begin
      if (k == idx) begin
        sel = ranks[k];
      end
    end
    return sel;
  endfunction

  // store and load slots together, these fill ports from 0 upward
  int mem_count;

  assign mem_count = int'(store_count) + int'(load_count);

  always_comb begin : place
    int alu_idx;
    int shift_idx;

    alu_idx = 0;
    for (int p = 0; p < distrib_pkg::num_ports; p++) begin
      // shift rank k sits on port 8-k
      shift_idx = distrib_pkg::num_ports - 1 - p;

      if (p < int'(store_count)) begin
        logical_ports[p] = pick(store_ranks, p);
      end else if (p < mem_count) begin
        logical_ports[p] = pick(load_ranks, p - int'(store_count));
      end else if (shift_idx < int'(shift_count)) begin
        logical_ports[p] = pick(shift_ranks, shift_idx);
      end else if (alu_idx < int'(alu_count)) begin
        // alu ops take whatever the memory ops and shifts leave free
        logical_ports[p] = pick(alu_ranks, alu_idx);
        alu_idx++;
      end else begin
        logical_ports[p] = distrib_pkg::no_slot;
      end
    end
  end

endmodule

// ==== hdl/port_rotate.sv ====
// ----------------------------------------------------------------------------
// rotation of the three port groups by the load and shift pointers
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module port_rotate (
  input  distrib_pkg::port_vec_t logical_ports,
  input  distrib_pkg::rot_t      load_rot,
  input  distrib_pkg::rot_t      shift_rot,
  output distrib_pkg::port_vec_t ports
);

  genvar g, i;
  generate
    for (g = 0; g < distrib_pkg::num_ports / distrib_pkg::group_size; g++) begin : g_group
      distrib_pkg::rot_t grp_rot;

      // memory groups follow the load pointer, the last group the shift pointer
      if (g == distrib_pkg::num_ports / distrib_pkg::group_size - 1) begin : g_shift
        assign grp_rot = shift_rot;
      end else begin : g_load
        assign grp_rot = load_rot;
      end

      // pointer at bit r: physical base+i carries logical base+((i+r) mod 3)
      for (i = 0; i < distrib_pkg::group_size; i++) begin : g_port
        localparam int base = g * distrib_pkg::group_size;
        localparam int step1 = base + (i + 1) % distrib_pkg::group_size;
        localparam int step2 = base + (i + 2) % distrib_pkg::group_size;

        assign ports[base+i] = grp_rot[1] ? logical_ports[step1] :
                               grp_rot[2] ? logical_ports[step2] :
                                            logical_ports[base+i];
      end
    end
  endgenerate

endmodule

// ==== hdl/rotation_ctrl.sv ====
// ----------------------------------------------------------------------------
// load and shift rotation pointers, advanced by count mod 3 each cycle
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module rotation_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  distrib_pkg::slot_cnt_t load_count,
  input  distrib_pkg::slot_cnt_t shift_count,
  output distrib_pkg::rot_t      load_rot,
  output distrib_pkg::rot_t      shift_rot
);

  // moves a one-hot pointer forward by cnt mod 3 places, bit r to bit r+1
  function automatic distrib_pkg::rot_t advance(
    input distrib_pkg::rot_t      ptr,
    input distrib_pkg::slot_cnt_t cnt
  );
    distrib_pkg::rot_t nxt;
    case (int'(cnt) % distrib_pkg::group_size)
      1:       nxt = {ptr[1:0], ptr[2]};
      2:       nxt = {ptr[0], ptr[2:1]};
      default: nxt = ptr;
    endcase
    return nxt;
  endfunction

  distrib_pkg::rot_t load_rot_next;
  distrib_pkg::rot_t shift_rot_next;

  assign load_rot_next  = advance(load_rot, load_count);
  assign shift_rot_next = advance(shift_rot, shift_count);

  // stall holds both pointers so a replayed bundle sees the same layout
  always_ff @(posedge clk) begin
    if (rst) begin
      load_rot  <= distrib_pkg::rot_reset;
      shift_rot <= distrib_pkg::rot_reset;
    end else if (!stall) begin
      load_rot  <= load_rot_next;
      shift_rot <= shift_rot_next;
    end
  end

endmodule

// ==== hdl/slot_select.sv ====
// ----------------------------------------------------------------------------
// ranked slot extraction for one instruction class mask
// ----------------------------------------------------------------------------
`timescale 1ns/100ps

module slot_select (
  input  distrib_pkg::slot_mask_t mask,
  output distrib_pkg::rank_vec_t  ranks,
  output distrib_pkg::slot_cnt_t  count
);

  // prefix[j] counts the set bits of mask below slot j
  distrib_pkg::slot_cnt_t prefix [distrib_pkg::num_slots+1];

  // raw rank hits, zero when the class has too few slots
  distrib_pkg::slot_mask_t hit [distrib_pkg::max_rank];

  always_comb begin
    prefix[0] = '0;
    for (int j = 0; j < distrib_pkg::num_slots; j++) begin
      prefix[j+1] = prefix[j] + distrib_pkg::slot_cnt_t'(mask[j]);
    end
  end

  // slot j is rank k when it is set and exactly k set slots sit below it
  genvar k, j;
  generate
    for (k = 0; k < distrib_pkg::max_rank; k++) begin : g_rank
      for (j = 0; j < distrib_pkg::num_slots; j++) begin : g_slot
        assign hit[k][j] = mask[j] && (prefix[j] == distrib_pkg::slot_cnt_t'(k));
      end

      // missing ranks read as an empty slot
      assign ranks[k] = (|hit[k]) ? hit[k] : distrib_pkg::no_slot;
    end
  endgenerate

  assign count = prefix[distrib_pkg::num_slots];

endmodule

// ==== list.f ====
+incdir+dv
hdl/distrib_pkg.sv
hdl/slot_select.sv
hdl/port_assign.sv
hdl/port_rotate.sv
hdl/rotation_ctrl.sv
hdl/distrib_top.sv
dv/distrib_tb.sv
